// ==== list.f ====
source/mem_sys_pkg.sv
source/axi_lite_if.sv
source/mem_array.sv
source/axi_sram_slave.sv
source/axi_read_arbiter.sv
source/mem_sys_top.sv
tb/tb_mem_sys.sv
+incdir+tb

// ==== tb/tb_mem_tasks.svh ====
// reference copy of the memory, updated on each b transfer
logic [data_w-1:0] ref_mem [mem_words];
bit                served_q [$];
// after reset the ifu is favored, as if the lsu was served last
bit                last_ifu = 1'b0;

function automatic axi_resp_e exp_resp(input logic [addr_w-1:0] addr);
  if ((addr >> 3) < mem_words) begin
    return resp_okay;
  end
  return resp_decerr;
endfunction

function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_w,
                                                  input logic [data_w-1:0] new_w,
                                                  input logic [strb_w-1:0] strb);
  logic [data_w-1:0] res;
  res = old_w;
  for (int i = 0; i < strb_w; i++) begin
    if (strb[i]) begin
      res[i*8 +: 8] = new_w[i*8 +: 8];
    end
  end
  return res;
endfunction

task automatic check_data(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                          input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic write_txn(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                         input logic [strb_w-1:0] strb, input int hold);
  axi_resp_e resp;
  @(posedge clk);
  lsu_aw_valid_i <= 1'b1;
  lsu_aw_addr_i  <= addr;
  @(negedge clk);
  while (!lsu_aw_ready_o) @(negedge clk);
  @(posedge clk);
  lsu_aw_valid_i <= 1'b0;
  lsu_w_valid_i  <= 1'b1;
  lsu_w_data_i   <= data;
  lsu_w_strb_i   <= strb;
  @(negedge clk);
  while (!lsu_w_ready_o) @(negedge clk);
  @(posedge clk);
  lsu_w_valid_i <= 1'b0;
  lsu_b_ready_i <= (hold == 0);
  @(negedge clk);
  while (!lsu_b_valid_o) @(negedge clk);
  resp = lsu_b_resp_o;
  repeat (hold) begin
    @(negedge clk);
    check_flag(lsu_b_valid_o, 1'b1, "b_valid held in stall");
    check_resp(lsu_b_resp_o, resp, "b_resp held in stall");
    check_flag(lsu_aw_ready_o, 1'b0, "aw accepted during b stall");
  end
  if (hold > 0) begin
    @(posedge clk);
    lsu_b_ready_i <= 1'b1;
    @(negedge clk);
  end
  // b transfer
  @(posedge clk);
  lsu_b_ready_i <= 1'b0;
  check_resp(resp, exp_resp(addr), "write resp");
  if (exp_resp(addr) == resp_okay) begin
    ref_mem[addr[3 +: idx_w]] = merge_bytes(ref_mem[addr[3 +: idx_w]], data, strb);
  end
endtask

task automatic read_txn(input bit ifu, input logic [addr_w-1:0] addr, input int hold,
                        output int lat);
  logic [data_w-1:0] data;
  axi_resp_e         resp;
  @(posedge clk);
  if (ifu) begin
    ifu_ar_valid_i <= 1'b1;
    ifu_ar_addr_i  <= addr;
    ifu_r_ready_i  <= (hold == 0);
  end else begin
    lsu_ar_valid_i <= 1'b1;
    lsu_ar_addr_i  <= addr;
    lsu_r_ready_i  <= (hold == 0);
  end
  @(negedge clk);
  while (!(ifu ? ifu_ar_ready_o : lsu_ar_ready_o)) @(negedge clk);
  // ar transfer, edge N
  @(posedge clk);
  served_q.push_back(ifu);
  last_ifu = ifu;
  if (ifu) begin
    ifu_ar_valid_i <= 1'b0;
  end else begin
    lsu_ar_valid_i <= 1'b0;
  end
  lat = 1;
  @(negedge clk);
  while (!(ifu ? ifu_r_valid_o : lsu_r_valid_o)) begin
    @(negedge clk);
    lat++;
  end
  data = ifu ? ifu_r_data_o : lsu_r_data_o;
  resp = ifu ? ifu_r_resp_o : lsu_r_resp_o;
  repeat (hold) begin
    @(negedge clk);
    check_flag(ifu ? ifu_r_valid_o : lsu_r_valid_o, 1'b1, "r_valid held in stall");
    check_data(ifu ? ifu_r_data_o : lsu_r_data_o, data, "r_data held in stall");
    check_resp(ifu ? ifu_r_resp_o : lsu_r_resp_o, resp, "r_resp held in stall");
    check_flag(ifu_ar_ready_o, 1'b0, "ifu ar accepted during r stall");
    check_flag(lsu_ar_ready_o, 1'b0, "lsu ar accepted during r stall");
  end
  if (hold > 0) begin
    @(posedge clk);
    if (ifu) begin
      ifu_r_ready_i <= 1'b1;
    end else begin
      lsu_r_ready_i <= 1'b1;
    end
    @(negedge clk);
  end
  @(posedge clk);
  if (ifu) begin
    ifu_r_ready_i <= 1'b0;
  end else begin
    lsu_r_ready_i <= 1'b0;
  end
  check_resp(resp, exp_resp(addr), "read resp");
  if (exp_resp(addr) == resp_okay) begin
    check_data(data, ref_mem[addr[3 +: idx_w]], "read data");
  end
endtask

task automatic test_reset();
  @(negedge clk);
  check_flag(ifu_ar_ready_o, 1'b1, "ifu ar_ready after reset");
  check_flag(lsu_ar_ready_o, 1'b1, "lsu ar_ready after reset");
  check_flag(lsu_aw_ready_o, 1'b1, "aw_ready after reset");
  check_flag(lsu_w_ready_o, 1'b0, "w_ready after reset");
  check_flag(ifu_r_valid_o, 1'b0, "ifu r_valid after reset");
  check_flag(lsu_r_valid_o, 1'b0, "lsu r_valid after reset");
  check_flag(lsu_b_valid_o, 1'b0, "b_valid after reset");
endtask

task automatic test_write_read();
  int lat;
  for (int i = 0; i < n_fill; i++) begin
    write_txn(i * 8, {$random(seed), $random(seed)}, '1, 0);
  end
  read_txn(1'b1, 0, 0, lat);
  check_flag(lat == 2, 1'b1, "r_valid at edge N+2");
  for (int i = 1; i < n_fill; i++) begin
    read_txn(i[0], i * 8, 0, lat);
  end
endtask

task automatic test_strobes();
  logic [31:0]       r;
  logic [addr_w-1:0] addr;
  logic [strb_w-1:0] strb;
  int                lat;
  for (int i = 0; i < n_strb; i++) begin
    r = $random(seed);
    // low address bits set on purpose, they are ignored
    addr = {r[3:0], r[14:12]};
    strb = r[11:4];
    if (strb == '1 || strb == '0) begin
      strb = 8'h5a;
    end
    write_txn(addr, {$random(seed), $random(seed)}, strb, 0);
    read_txn(r[15], addr, 0, lat);
  end
endtask

task automatic test_decerr();
  int lat;
  read_txn(1'b0, mem_words * 8, 0, lat);
  read_txn(1'b1, 32'h8000_0000, 0, lat);
  // both of these alias words 3 and 2 in the index bits
  write_txn((mem_words + 3) * 8, {$random(seed), $random(seed)}, '1, 0);
  write_txn(32'h0001_0010, {$random(seed), $random(seed)}, '1, 0);
  read_txn(1'b0, 3 * 8, 0, lat);
  read_txn(1'b1, 2 * 8, 0, lat);
endtask

task automatic test_arbitration();
  logic [31:0] r;
  bit          exp_ifu;
  int          lat_i;
  int          lat_l;
  for (int k = 0; k < n_arb; k++) begin
    r = $random(seed);
    // a lone read first so the tie winner alternates
    read_txn(k[0], 32'(r[3:0]) << 3, 0, lat_i);
    exp_ifu = !last_ifu;
    served_q.delete();
    fork
      read_txn(1'b1, 32'(r[7:4]) << 3, 0, lat_i);
      read_txn(1'b0, 32'(r[11:8]) << 3, 0, lat_l);
    join
    check_flag(served_q[0], exp_ifu, "round-robin winner");
  end
endtask

task automatic test_backpressure();
  logic [31:0]       r;
  logic [addr_w-1:0] addr;
  int                lat;
  for (int i = 0; i < n_bp; i++) begin
    r = $random(seed);
    addr = 32'(r[3:0]) << 3;
    write_txn(addr, {$random(seed), $random(seed)}, r[15:8], 1 + r[6:4]);
    read_txn(r[7], addr, 1 + r[18:16], lat);
  end
endtask

// ==== tb/tb_mem_sys.sv ====
`timescale 1ns/1ps

module tb_mem_sys import mem_sys_pkg::*; ();

  localparam int n_fill = 16;
  localparam int n_strb = 6;
  localparam int n_dec  = 6;
  localparam int n_arb  = 6;
  localparam int n_bp   = 4;
  // reset check counts as one transaction, each arbitration round has three reads
  localparam int n_txn  = 1 + 2 * n_fill + 2 * n_strb + n_dec + 3 * n_arb + 2 * n_bp;
  localparam int timeout_cycles = n_txn * 20;

  logic              clk;
  logic              rst;
  logic              ifu_ar_valid_i;
  logic [addr_w-1:0] ifu_ar_addr_i;
  logic              ifu_ar_ready_o;
  logic              ifu_r_valid_o;
  logic [data_w-1:0] ifu_r_data_o;
  axi_resp_e         ifu_r_resp_o;
  logic              ifu_r_ready_i;
  logic              lsu_ar_valid_i;
  logic [addr_w-1:0] lsu_ar_addr_i;
  logic              lsu_ar_ready_o;
  logic              lsu_r_valid_o;
  logic [data_w-1:0] lsu_r_data_o;
  axi_resp_e         lsu_r_resp_o;
  logic              lsu_r_ready_i;
  logic              lsu_aw_valid_i;
  logic [addr_w-1:0] lsu_aw_addr_i;
  logic              lsu_aw_ready_o;
  logic              lsu_w_valid_i;
  logic [data_w-1:0] lsu_w_data_i;
  logic [strb_w-1:0] lsu_w_strb_i;
  logic              lsu_w_ready_o;
  logic              lsu_b_valid_o;
  axi_resp_e         lsu_b_resp_o;
  logic              lsu_b_ready_i;

  integer seed = 32'h1614;
  int     err_cnt = 0;
  int     chk_cnt = 0;
  int     cycle_cnt = 0;

  mem_sys_top UUT (
    .clk            (clk),
    .rst            (rst),
    .ifu_ar_valid_i (ifu_ar_valid_i),
    .ifu_ar_addr_i  (ifu_ar_addr_i),
    .ifu_ar_ready_o (ifu_ar_ready_o),
    .ifu_r_valid_o  (ifu_r_valid_o),
    .ifu_r_data_o   (ifu_r_data_o),
    .ifu_r_resp_o   (ifu_r_resp_o),
    .ifu_r_ready_i  (ifu_r_ready_i),
    .lsu_ar_valid_i (lsu_ar_valid_i),
    .lsu_ar_addr_i  (lsu_ar_addr_i),
    .lsu_ar_ready_o (lsu_ar_ready_o),
    .lsu_r_valid_o  (lsu_r_valid_o),
    .lsu_r_data_o   (lsu_r_data_o),
    .lsu_r_resp_o   (lsu_r_resp_o),
    .lsu_r_ready_i  (lsu_r_ready_i),
    .lsu_aw_valid_i (lsu_aw_valid_i),
    .lsu_aw_addr_i  (lsu_aw_addr_i),
    .lsu_aw_ready_o (lsu_aw_ready_o),
    .lsu_w_valid_i  (lsu_w_valid_i),
    .lsu_w_data_i   (lsu_w_data_i),
    .lsu_w_strb_i   (lsu_w_strb_i),
    .lsu_w_ready_o  (lsu_w_ready_o),
    .lsu_b_valid_o  (lsu_b_valid_o),
    .lsu_b_resp_o   (lsu_b_resp_o),
    .lsu_b_ready_i  (lsu_b_ready_i)
  );

  `include "tb_mem_tasks.svh"

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: simulation did not finish");
      err_cnt = err_cnt + 1;
      $display("errors: %0d, checks: %0d", err_cnt, chk_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    ifu_ar_valid_i = 1'b0;
    ifu_ar_addr_i  = '0;
    ifu_r_ready_i  = 1'b0;
    lsu_ar_valid_i = 1'b0;
    lsu_ar_addr_i  = '0;
    lsu_r_ready_i  = 1'b0;
    lsu_aw_valid_i = 1'b0;
    lsu_aw_addr_i  = '0;
    lsu_w_valid_i  = 1'b0;
    lsu_w_data_i   = '0;
    lsu_w_strb_i   = '0;
    lsu_b_ready_i  = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    test_reset();
    test_write_read();
    test_strobes();
    test_decerr();
    test_arbitration();
    test_backpressure();

    repeat (2) @(posedge clk);
    $display("errors: %0d, checks: %0d", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== source/mem_sys_top.sv ====
`timescale 1ns/1ps

module mem_sys_top import mem_sys_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  input  logic              ifu_ar_valid_i,
  input  logic [addr_w-1:0] ifu_ar_addr_i,
  output logic              ifu_ar_ready_o,
  output logic              ifu_r_valid_o,
  output logic [data_w-1:0] ifu_r_data_o,
  output axi_resp_e         ifu_r_resp_o,
  input  logic              ifu_r_ready_i,

  input  logic              lsu_ar_valid_i,
  input  logic [addr_w-1:0] lsu_ar_addr_i,
  output logic              lsu_ar_ready_o,
  output logic              lsu_r_valid_o,
  output logic [data_w-1:0] lsu_r_data_o,
  output axi_resp_e         lsu_r_resp_o,
  input  logic              lsu_r_ready_i,
  input  logic              lsu_aw_valid_i,
  input  logic [addr_w-1:0] lsu_aw_addr_i,
  output logic              lsu_aw_ready_o,
  input  logic              lsu_w_valid_i,
  input  logic [data_w-1:0] lsu_w_data_i,
  input  logic [strb_w-1:0] lsu_w_strb_i,
  output logic              lsu_w_ready_o,
  output logic              lsu_b_valid_o,
  output axi_resp_e         lsu_b_resp_o,
  input  logic              lsu_b_ready_i
);

  axi_lite_if lsu_bus ();
  axi_lite_if mem_bus ();

  // lsu ports onto the bus
  assign lsu_bus.ar_valid = lsu_ar_valid_i;
  assign lsu_bus.ar_addr  = lsu_ar_addr_i;
  assign lsu_ar_ready_o   = lsu_bus.ar_ready;
  assign lsu_r_valid_o    = lsu_bus.r_valid;
  assign lsu_r_data_o     = lsu_bus.r_data;
  assign lsu_r_resp_o     = lsu_bus.r_resp;
  assign lsu_bus.r_ready  = lsu_r_ready_i;
  assign lsu_bus.aw_valid = lsu_aw_valid_i;
  assign lsu_bus.aw_addr  = lsu_aw_addr_i;
  assign lsu_aw_ready_o   = lsu_bus.aw_ready;
  assign lsu_bus.w_valid  = lsu_w_valid_i;
  assign lsu_bus.w_data   = lsu_w_data_i;
  assign lsu_bus.w_strb   = lsu_w_strb_i;
  assign lsu_w_ready_o    = lsu_bus.w_ready;
  assign lsu_b_valid_o    = lsu_bus.b_valid;
  assign lsu_b_resp_o     = lsu_bus.b_resp;
  assign lsu_bus.b_ready  = lsu_b_ready_i;

  axi_read_arbiter u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_ar_valid_i (ifu_ar_valid_i),
    .ifu_ar_addr_i  (ifu_ar_addr_i),
    .ifu_ar_ready_o (ifu_ar_ready_o),
    .ifu_r_valid_o  (ifu_r_valid_o),
    .ifu_r_data_o   (ifu_r_data_o),
    .ifu_r_resp_o   (ifu_r_resp_o),
    .ifu_r_ready_i  (ifu_r_ready_i),
    .lsu            (lsu_bus.slave),
    .mem            (mem_bus.master)
  );

  axi_sram_slave u_slave (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus.slave)
  );

endmodule

// ==== source/axi_read_arbiter.sv ====
`timescale 1ns/1ps

module axi_read_arbiter import mem_sys_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              ifu_ar_valid_i,
  input  logic [addr_w-1:0] ifu_ar_addr_i,
  output logic              ifu_ar_ready_o,
  output logic              ifu_r_valid_o,
  output logic [data_w-1:0] ifu_r_data_o,
  output axi_resp_e         ifu_r_resp_o,
  input  logic              ifu_r_ready_i,
  axi_lite_if.slave         lsu,
  axi_lite_if.master        mem
);

  arb_state_e state;
  logic       prefer_ifu;
  logic       sel_ifu;
  logic       sel_lsu;
  logic       ar_fire;
  logic       r_fire;

  // pick a master only while idle
  assign sel_ifu = (state == arb_idle) && ifu_ar_valid_i && (!lsu.ar_valid || prefer_ifu);
  assign sel_lsu = (state == arb_idle) && lsu.ar_valid && !sel_ifu;

  assign ar_fire = mem.ar_valid && mem.ar_ready;
  assign r_fire  = mem.r_valid && mem.r_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= arb_idle;
      prefer_ifu <= 1'b1;
    end else begin
      case (state)
        arb_idle: begin
          if (ar_fire) begin
            state      <= sel_ifu ? arb_ifu : arb_lsu;
            // whoever was just served loses the next tie
            prefer_ifu <= !sel_ifu;
          end
        end
        arb_ifu, arb_lsu: begin
          if (r_fire) begin
            state <= arb_idle;
          end
        end
        default: begin
          state <= arb_idle;
        end
      endcase
    end
  end

  // ar channel toward the slave
  assign mem.ar_valid = sel_ifu || sel_lsu;
  assign mem.ar_addr  = sel_ifu ? ifu_ar_addr_i : lsu.ar_addr;
  // idle readies stay high unless the other master is picked
  assign ifu_ar_ready_o = (state == arb_idle) && mem.ar_ready && !sel_lsu;
  assign lsu.ar_ready   = (state == arb_idle) && mem.ar_ready && !sel_ifu;

  // r channel back to the granted master
  assign ifu_r_valid_o = (state == arb_ifu) && mem.r_valid;
  assign ifu_r_data_o  = mem.r_data;
  assign ifu_r_resp_o  = mem.r_resp;
  assign lsu.r_valid   = (state == arb_lsu) && mem.r_valid;
  assign lsu.r_data    = mem.r_data;
  assign lsu.r_resp    = mem.r_resp;

  always_comb begin
    case (state)
      arb_ifu: mem.r_ready = ifu_r_ready_i;
      arb_lsu: mem.r_ready = lsu.r_ready;
      default: mem.r_ready = 1'b0;
    endcase
  end

  // lsu write path goes straight to the slave
  assign mem.aw_valid = lsu.aw_valid;
  assign mem.aw_addr  = lsu.aw_addr;
  assign lsu.aw_ready = mem.aw_ready;
  assign mem.w_valid  = lsu.w_valid;
  assign mem.w_data   = lsu.w_data;
  assign mem.w_strb   = lsu.w_strb;
  assign lsu.w_ready  = mem.w_ready;
  assign lsu.b_valid  = mem.b_valid;
  assign lsu.b_resp   = mem.b_resp;
  assign mem.b_ready  = lsu.b_ready;

  a_one_grant: assert property (
    @(posedge clk) disable iff (rst)
    !(ifu_ar_valid_i && ifu_ar_ready_o && lsu.ar_valid && lsu.ar_ready) &&
    !(ifu_r_valid_o && lsu.r_valid)
  );

  // a slave response only ever arrives for a held grant
  a_resp_owned: assert property (
    @(posedge clk) disable iff (rst)
    mem.r_valid |-> state != arb_idle
  );

endmodule

// ==== source/axi_sram_slave.sv ====
`timescale 1ns/1ps

module axi_sram_slave import mem_sys_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  axi_lite_if.slave bus
);

  rd_state_e rd_state;
  wr_state_e wr_state;

  logic [idx_w-1:0]  rd_idx;
  logic              rd_ok;
  logic [idx_w-1:0]  wr_idx;
  logic              wr_ok;
  logic [data_w-1:0] wr_data;
  logic [strb_w-1:0] wr_strb;

  logic              arr_rd_en;
  logic [data_w-1:0] arr_rd_data;
  logic              arr_wr_en;

  // word address must fall inside the array
  function automatic logic addr_in_range(input logic [addr_w-1:0] addr);
    return addr[addr_w-1:3] < (addr_w-3)'(mem_words);
  endfunction

  // bits 2..0 ignored, accesses are 64-bit aligned
  function automatic logic [idx_w-1:0] word_idx(input logic [addr_w-1:0] addr);
    return addr[3 +: idx_w];
  endfunction

  // read channel
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= rs_idle;
    end else begin
      case (rd_state)
        rs_idle: begin
          if (bus.ar_valid) begin
            rd_state <= rs_access;
          end
        end
        rs_access: begin
          rd_state <= rs_resp;
        end
        rs_resp: begin
          if (bus.r_ready) begin
            rd_state <= rs_idle;
          end
        end
        default: begin
          rd_state <= rs_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_state == rs_idle && bus.ar_valid) begin
      rd_idx <= word_idx(bus.ar_addr);
      rd_ok  <= addr_in_range(bus.ar_addr);
    end
  end

  assign bus.ar_ready = (rd_state == rs_idle);
  assign bus.r_valid  = (rd_state == rs_resp);
  // decode errors return zero data
  assign bus.r_data   = rd_ok ? arr_rd_data : '0;
  assign bus.r_resp   = rd_ok ? resp_okay : resp_decerr;
  assign arr_rd_en    = (rd_state == rs_access) && rd_ok;

  // write channel
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= ws_idle;
    end else begin
      case (wr_state)
        ws_idle: begin
          if (bus.aw_valid) begin
            wr_state <= ws_data;
          end
        end
        ws_data: begin
          if (bus.w_valid) begin
            wr_state <= ws_resp;
          end
        end
        ws_resp: begin
          if (bus.b_ready) begin
            wr_state <= ws_idle;
          end
        end
        default: begin
          wr_state <= ws_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_state == ws_idle && bus.aw_valid) begin
      wr_idx <= word_idx(bus.aw_addr);
      wr_ok  <= addr_in_range(bus.aw_addr);
    end
    if (wr_state == ws_data && bus.w_valid) begin
      wr_data <= bus.w_data;
      wr_strb <= bus.w_strb;
    end
  end

  assign bus.aw_ready = (wr_state == ws_idle);
  assign bus.w_ready  = (wr_state == ws_data);
  assign bus.b_valid  = (wr_state == ws_resp);
  assign bus.b_resp   = wr_ok ? resp_okay : resp_decerr;
  // commit on the b handshake, out of range writes are dropped
  assign arr_wr_en    = (wr_state == ws_resp) && bus.b_ready && wr_ok;

  mem_array u_mem_array (
    .clk       (clk),
    .rd_en_i   (arr_rd_en),
    .rd_idx_i  (rd_idx),
    .rd_data_o (arr_rd_data),
    .wr_en_i   (arr_wr_en),
    .wr_idx_i  (wr_idx),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb)
  );

  a_r_hold: assert property (
    @(posedge clk) disable iff (rst)
    bus.r_valid && !bus.r_ready |=>
      bus.r_valid && $stable(bus.r_data) && $stable(bus.r_resp)
  );

  a_b_hold: assert property (
    @(posedge clk) disable iff (rst)
    bus.b_valid && !bus.b_ready |=> bus.b_valid && $stable(bus.b_resp)
  );

endmodule

// ==== source/mem_array.sv ====
`timescale 1ns/1ps

module mem_array import mem_sys_pkg::*; (
  input  logic              clk,
  input  logic              rd_en_i,
  input  logic [idx_w-1:0]  rd_idx_i,
  output logic [data_w-1:0] rd_data_o,
  input  logic              wr_en_i,
  input  logic [idx_w-1:0]  wr_idx_i,
  input  logic [data_w-1:0] wr_data_i,
  input  logic [strb_w-1:0] wr_strb_i
);

  logic [data_w-1:0] mem [mem_words];

  // registered read port, output holds between reads
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_idx_i];
    end
  end

  // byte lanes gated by strobe
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wr_strb_i[b]) begin
          mem[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== source/axi_lite_if.sv ====
`timescale 1ns/1ps

interface axi_lite_if import mem_sys_pkg::*; ();

  logic              ar_valid;
  logic              ar_ready;
  logic [addr_w-1:0] ar_addr;

  logic              r_valid;
  logic              r_ready;
  logic [data_w-1:0] r_data;
  axi_resp_e         r_resp;

  logic              aw_valid;
  logic              aw_ready;
  logic [addr_w-1:0] aw_addr;

  logic              w_valid;
  logic              w_ready;
  logic [data_w-1:0] w_data;
  logic [strb_w-1:0] w_strb;

  logic              b_valid;
  logic              b_ready;
  axi_resp_e         b_resp;

  modport master (
    output ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    input  ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
  );

  modport slave (
    input  ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    output ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
  );

endinterface

// ==== source/mem_sys_pkg.sv ====
package mem_sys_pkg;

  localparam int addr_w    = 32;
  localparam int data_w    = 64;
  localparam int strb_w    = data_w / 8;
  localparam int mem_words = 256;
  localparam int idx_w     = 8;

  // AXI response codes
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    rs_idle,
    rs_access,
    rs_resp
  } rd_state_e;

  typedef enum logic [1:0] {
    ws_idle,
    ws_data,
    ws_resp
  } wr_state_e;

  typedef enum logic [1:0] {
    arb_idle,
    arb_ifu,
    arb_lsu
  } arb_state_e;

endpackage
